//--- source/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

//////////////////////////////
// Cache geometry
//////////////////////////////

// Ways per set
`define DCACHE_WAYS 4

// Number of sets
`define DCACHE_SETS 16

`define DCACHE_LINE_WORDS 16  // Words per line

// Byte address and tag widths
`define DCACHE_ADDR_W 32
`define DCACHE_TAG_W 22

`endif

//--- source/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

  typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] strobe_t;  // One bit per byte lane

  typedef logic [`DCACHE_TAG_W-1:0] tag_t;
  typedef logic [$clog2(`DCACHE_SETS)-1:0] index_t;
  typedef logic [$clog2(`DCACHE_LINE_WORDS)-1:0] offset_t;
  typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

  // Replacement age, 0 is most recent
  typedef logic [1:0] age_t;

  // One tag array entry
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // Ages of all ways of one set
  typedef age_t [`DCACHE_WAYS-1:0] age_set_t;

endpackage

//--- source/cache_ram.sv
module cache_ram #(
  parameter type entry_t = logic,
  parameter int depth = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [$clog2(depth)-1:0] rd_addr,
  output entry_t                   rd_data,
  input  logic                     wr_en,
  input  logic [$clog2(depth)-1:0] wr_addr,
  input  entry_t                   wr_data
);

  entry_t mem [depth];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < depth; i++)
        mem[i] <= '0;
      rd_data <= '0;
    end
    else
    begin
      if (wr_en)
        mem[wr_addr] <= wr_data;
      // Write-first, a read of the address being written sees the new entry
      if (wr_en && wr_addr == rd_addr)
        rd_data <= wr_data;
      else
        rd_data <= mem[rd_addr];
    end
  end

  a_wr_in_range: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> int'(wr_addr) < depth
  ) else $error("cache_ram write beyond depth %0d", depth);

endmodule

//--- source/way_select.sv
`include "dcache_settings.svh"

module way_select
  import dcache_pkg::*;
(
  input  tag_t                              lookup_tag,
  input  tag_entry_t [`DCACHE_WAYS-1:0]     entries,
  input  age_set_t                          ages,
  input  logic                              use_victim,
  output logic                              hit,
  output way_t                              hit_way,
  output way_t                              victim_way,
  output logic                              victim_dirty,
  output tag_t                              victim_tag,
  output age_set_t                          new_ages
);

  logic [`DCACHE_WAYS-1:0] match;
  logic found_free;
  way_t touch_way;
  age_t touch_age;

  //////////////////////////////
  // Hit detection
  //////////////////////////////

  always_comb
  begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `DCACHE_WAYS; w++)
    begin
      match[w] = entries[w].valid && entries[w].tag == lookup_tag;
      if (match[w])
      begin
        hit = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Same tag installed twice in one set
  always_comb
  begin
    assert ($onehot0(match)) else $error("way_select: several ways match tag %h", lookup_tag);
  end

  //////////////////////////////
  // Victim choice
  //////////////////////////////

  always_comb
  begin
    found_free = 1'b0;
    victim_way = '0;
    for (int w = 0; w < `DCACHE_WAYS; w++)
    begin
      if (!found_free && !entries[w].valid)
      begin
        victim_way = way_t'(w);
        found_free = 1'b1;
      end
    end
    if (!found_free)
    begin
      for (int w = 1; w < `DCACHE_WAYS; w++)
        if (ages[w] > ages[victim_way])  // Strict, lowest index wins a tie
          victim_way = way_t'(w);
    end
  end

  assign victim_dirty = entries[victim_way].valid && entries[victim_way].dirty;
  assign victim_tag = entries[victim_way].tag;

  // Age update for the touched way
  assign touch_way = use_victim ? victim_way : hit_way;
  assign touch_age = ages[touch_way];

  always_comb
  begin
    for (int w = 0; w < `DCACHE_WAYS; w++)
    begin
      if (way_t'(w) == touch_way)
        new_ages[w] = '0;
      else if (ages[w] <= touch_age)
        new_ages[w] = ages[w] + age_t'(1);
      else
        new_ages[w] = ages[w];
    end
  end

endmodule

//--- source/burst_engine.sv
module burst_engine
  import dcache_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  logic    write_back,
  input  addr_t   line_addr,
  input  way_t    way,
  input  logic    mem_data_ok,
  input  word_t   mem_rdata,
  input  word_t   array_rdata,
  output logic    mem_req,
  output logic    mem_we,
  output addr_t   mem_addr,
  output word_t   mem_wdata,
  output offset_t array_raddr,
  output logic    fill_en,
  output way_t    fill_way,
  output offset_t fill_offset,
  output word_t   fill_data,
  output logic    done
);

  logic busy;
  offset_t cnt;  // Word of the current beat
  logic beat;
  logic last_beat;
  logic wb_q;
  addr_t addr_q;
  way_t way_q;

  assign beat = busy && mem_data_ok;
  assign last_beat = beat && cnt == '1;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      cnt <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= last_beat;
      if (start && !busy)
        busy <= 1'b1;
      else if (last_beat)
        busy <= 1'b0;
      if (beat)
        cnt <= cnt + offset_t'(1);  // Wraps to 0 after the last word
    end
  end

  always_ff @(posedge clk)
  begin
    if (start && !busy)
    begin
      wb_q <= write_back;
      addr_q <= line_addr;
      way_q <= way;
    end
  end

  //////////////////////////////
  // Memory side
  //////////////////////////////

  assign mem_req = busy;
  assign mem_we = busy && wb_q;
  assign mem_addr = addr_q;
  assign mem_wdata = array_rdata;

  // Read one word ahead so the array output tracks cnt
  assign array_raddr = beat ? cnt + offset_t'(1) : cnt;

  // Refill writes
  assign fill_en = beat && !wb_q;
  assign fill_way = way_q;
  assign fill_offset = cnt;
  assign fill_data = mem_rdata;

  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst) start |-> !busy
  ) else $error("burst_engine: start while a burst runs");

endmodule

//--- source/dcache_ctrl.sv
`include "dcache_settings.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cpu_req,
  input  logic                          cpu_we,
  input  addr_t                         cpu_addr,
  input  word_t                         cpu_wdata,
  input  strobe_t                       cpu_strobe,
  input  logic                          hit,
  input  way_t                          hit_way,
  input  way_t                          victim_way,
  input  logic                          victim_dirty,
  input  tag_t                          victim_tag,
  input  word_t [`DCACHE_WAYS-1:0]      data_rdata,
  input  logic                          burst_done,
  output logic                          cpu_ready,
  output logic                          cpu_ok,
  output word_t                         cpu_rdata,
  output index_t                        lookup_index,
  output offset_t                       lookup_offset,
  output tag_t                          lookup_tag,
  output logic                          use_victim,
  output logic [`DCACHE_WAYS-1:0]       tag_wr_en,
  output tag_entry_t                    tag_wr_data,
  output logic [`DCACHE_WAYS-1:0]       data_wr_en,
  output word_t                         data_wr_data,
  output logic                          age_wr_en,
  output logic                          burst_start,
  output logic                          burst_write_back,
  output addr_t                         burst_line_addr,
  output way_t                          burst_way
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_write_back,
    st_refill,
    st_install
  } state_t;

  state_t state;
  state_t state_next;

  // Held request
  addr_t req_addr;
  logic req_we;
  word_t req_wdata;
  strobe_t req_strobe;
  way_t vict_q;

  tag_t req_tag;
  index_t req_index;
  offset_t req_offset;
  word_t hit_word;
  word_t merged;

  assign req_offset = req_addr[2 +: $bits(offset_t)];
  assign req_index = req_addr[2 + $bits(offset_t) +: $bits(index_t)];
  assign req_tag = req_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];

  // Arrays read the incoming address while idle
  assign lookup_index = (state == st_idle) ?
                        cpu_addr[2 + $bits(offset_t) +: $bits(index_t)] : req_index;
  assign lookup_offset = (state == st_idle) ? cpu_addr[2 +: $bits(offset_t)] : req_offset;
  assign lookup_tag = req_tag;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= state_next;
  end

  always_ff @(posedge clk)
  begin
    if (state == st_idle && cpu_req)
    begin
      req_addr <= cpu_addr;
      req_we <= cpu_we;
      req_wdata <= cpu_wdata;
      req_strobe <= cpu_strobe;
    end
    if (state == st_lookup && !hit)
      vict_q <= victim_way;
  end

  //////////////////////////////
  // Request FSM
  //////////////////////////////

  always_comb
  begin
    state_next = state;
    cpu_ok = 1'b0;
    use_victim = 1'b0;
    tag_wr_en = '0;
    data_wr_en = '0;
    age_wr_en = 1'b0;
    burst_start = 1'b0;
    burst_write_back = 1'b0;
    burst_way = vict_q;
    burst_line_addr = {req_tag, req_index, offset_t'(0), 2'b00};
    case (state)
      st_idle:
        if (cpu_req)
          state_next = st_lookup;
      st_lookup:
        if (hit)
        begin
          cpu_ok = 1'b1;
          age_wr_en = 1'b1;
          state_next = st_idle;
          if (req_we)
          begin
            data_wr_en[hit_way] = 1'b1;
            tag_wr_en[hit_way] = 1'b1;  // Mark dirty
          end
        end
        else
        begin
          burst_start = 1'b1;
          burst_way = victim_way;
          burst_write_back = victim_dirty;
          if (victim_dirty)
          begin
            burst_line_addr = {victim_tag, req_index, offset_t'(0), 2'b00};
            state_next = st_write_back;
          end
          else
            state_next = st_refill;
        end
      st_write_back:
        if (burst_done)
        begin
          burst_start = 1'b1;  // Refill of the same way follows
          state_next = st_refill;
        end
      st_refill:
        if (burst_done)
          state_next = st_install;
      st_install:
      begin
        tag_wr_en[vict_q] = 1'b1;
        age_wr_en = 1'b1;
        use_victim = 1'b1;
        state_next = st_lookup;  // Retried as a hit
      end
      default:
        state_next = st_idle;
    endcase
  end

  // Clean on install, dirty on a write hit
  assign tag_wr_data = '{valid: 1'b1, dirty: state == st_lookup, tag: req_tag};

  // Byte merge
  always_comb
  begin
    hit_word = data_rdata[hit_way];
    merged = hit_word;
    for (int b = 0; b < $bits(strobe_t); b++)
      if (req_strobe[b])
        merged[8*b +: 8] = req_wdata[8*b +: 8];
  end

  assign data_wr_data = merged;
  assign cpu_rdata = req_we ? merged : hit_word;
  assign cpu_ready = state == st_idle;

  a_retry_hits: assert property (
    @(posedge clk) disable iff (rst) state == st_install |=> hit
  ) else $error("dcache_ctrl: lookup after install missed");

endmodule

//--- source/dcache_top.sv
`include "dcache_settings.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    cpu_req,
  input  logic    cpu_we,
  input  addr_t   cpu_addr,
  input  word_t   cpu_wdata,
  input  strobe_t cpu_strobe,
  output logic    cpu_ready,
  output logic    cpu_ok,
  output word_t   cpu_rdata,
  output logic    mem_req,
  output logic    mem_we,
  output addr_t   mem_addr,
  output word_t   mem_wdata,
  input  logic    mem_data_ok,
  input  word_t   mem_rdata
);

  index_t lookup_index;
  offset_t lookup_offset;
  tag_t lookup_tag;
  logic use_victim;
  logic hit;
  way_t hit_way;
  way_t victim_way;
  logic victim_dirty;
  tag_t victim_tag;
  age_set_t ages;
  age_set_t new_ages;
  logic age_wr_en;

  tag_entry_t [`DCACHE_WAYS-1:0] entries;
  logic [`DCACHE_WAYS-1:0] tag_wr_en;
  tag_entry_t tag_wr_data;

  word_t [`DCACHE_WAYS-1:0] data_rdata;
  logic [`DCACHE_WAYS-1:0] data_wr_en;
  logic [`DCACHE_WAYS-1:0] data_we;
  word_t data_wr_data;
  word_t data_wdata;
  logic [$bits(index_t)+$bits(offset_t)-1:0] data_raddr;
  logic [$bits(index_t)+$bits(offset_t)-1:0] data_waddr;

  logic burst_start;
  logic burst_write_back;
  addr_t burst_line_addr;
  way_t burst_way;
  logic burst_done;
  offset_t array_raddr;
  logic fill_en;
  way_t fill_way;
  offset_t fill_offset;
  word_t fill_data;

  dcache_ctrl u_ctrl (
    .clk, .rst, .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_strobe,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .data_rdata, .burst_done,
    .cpu_ready, .cpu_ok, .cpu_rdata, .lookup_index, .lookup_offset, .lookup_tag,
    .use_victim, .tag_wr_en, .tag_wr_data, .data_wr_en, .data_wr_data, .age_wr_en,
    .burst_start, .burst_write_back, .burst_line_addr, .burst_way
  );

  way_select u_way_select (
    .lookup_tag, .entries, .ages, .use_victim,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .new_ages
  );

  burst_engine u_burst (
    .clk, .rst, .start(burst_start), .write_back(burst_write_back),
    .line_addr(burst_line_addr), .way(burst_way), .mem_data_ok, .mem_rdata,
    .array_rdata(data_rdata[fill_way]), .mem_req, .mem_we, .mem_addr, .mem_wdata,
    .array_raddr, .fill_en, .fill_way, .fill_offset, .fill_data, .done(burst_done)
  );

  //////////////////////////////
  // Storage arrays
  //////////////////////////////

  // Burst owns the data port offset while it runs
  assign data_raddr = {lookup_index, (burst_start || mem_req) ? array_raddr : lookup_offset};
  assign data_waddr = {lookup_index, fill_en ? fill_offset : lookup_offset};
  assign data_wdata = fill_en ? fill_data : data_wr_data;

  for (genvar w = 0; w < `DCACHE_WAYS; w++)
  begin : g_way
    assign data_we[w] = data_wr_en[w] || (fill_en && fill_way == way_t'(w));

    cache_ram #(.entry_t(tag_entry_t), .depth(`DCACHE_SETS)) u_tag (
      .clk, .rst, .rd_addr(lookup_index), .rd_data(entries[w]),
      .wr_en(tag_wr_en[w]), .wr_addr(lookup_index), .wr_data(tag_wr_data)
    );

    cache_ram #(.entry_t(word_t), .depth(`DCACHE_SETS * `DCACHE_LINE_WORDS)) u_data (
      .clk, .rst, .rd_addr(data_raddr), .rd_data(data_rdata[w]),
      .wr_en(data_we[w]), .wr_addr(data_waddr), .wr_data(data_wdata)
    );
  end

  cache_ram #(.entry_t(age_set_t), .depth(`DCACHE_SETS)) u_age (
    .clk, .rst, .rd_addr(lookup_index), .rd_data(ages),
    .wr_en(age_wr_en), .wr_addr(lookup_index), .wr_data(new_ages)
  );

endmodule

//--- verification/mem_bus_model.sv
`include "dcache_settings.svh"

module mem_bus_model
  import dcache_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 mem_req,
  input  logic                                 mem_we,
  input  addr_t                                mem_addr,
  input  word_t                                mem_wdata,
  output logic                                 mem_data_ok,
  output word_t                                mem_rdata,
  output int                                   wb_count,
  output addr_t                                wb_addr,
  output word_t [`DCACHE_LINE_WORDS-1:0]       wb_line
);

  timeunit 1ns;
  timeprecision 100ps;

  word_t store [addr_t];  // Only words written back
  addr_t wb_log [$];
  offset_t beat_cnt;

  function automatic word_t mem_pattern(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t stored_word(addr_t a);
    if (store.exists(a))
      return store[a];
    return mem_pattern(a);
  endfunction

  initial
  begin
    mem_data_ok = 1'b0;
    mem_rdata = '0;
    wb_count = 0;
    wb_addr = '0;
    wb_line = '0;
    beat_cnt = '0;
  end

  //////////////////////////////
  // Burst beats
  //////////////////////////////

  always @(posedge clk)
  begin
    if (rst)
      beat_cnt = '0;
    else if (mem_req && mem_data_ok)
    begin
      if (mem_we)
      begin
        store[{mem_addr[31:6], beat_cnt, 2'b00}] = mem_wdata;
        wb_line[beat_cnt] = mem_wdata;
        if (beat_cnt == '1)
        begin
          wb_log.push_back(mem_addr);
          wb_addr = wb_log[$];
          wb_count = wb_log.size();
        end
      end
      beat_cnt = beat_cnt + offset_t'(1);
    end
    #2;
    // Roughly 60% of cycles carry a word
    mem_data_ok = mem_req && (($urandom % 10) < 6);
    mem_rdata = mem_req ? stored_word({mem_addr[31:6], beat_cnt, 2'b00}) : '0;
  end

endmodule

//--- verification/dcache_tb.sv
`include "dcache_settings.svh"

module dcache_tb
  import dcache_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period = 40;
  localparam int reset_cycles = 10;
  localparam int fixed_ops = 14;
  localparam int random_ops = 300;
  localparam real cycles_per_op = 34.0 / 0.6 + 8.0;  // Two stalled bursts and overhead

  logic clk = 1'b0;
  logic rst;
  logic cpu_req;
  logic cpu_we;
  addr_t cpu_addr;
  word_t cpu_wdata;
  strobe_t cpu_strobe;
  logic cpu_ready;
  logic cpu_ok;
  word_t cpu_rdata;
  logic mem_req;
  logic mem_we;
  addr_t mem_addr;
  word_t mem_wdata;
  logic mem_data_ok;
  word_t mem_rdata;
  int wb_count;
  addr_t wb_addr;
  word_t [`DCACHE_LINE_WORDS-1:0] wb_line;

  word_t model_mem [addr_t];  // CPU view of memory
  int mem_busy = 0;
  int last_latency;
  int last_mem_cycles;
  word_t last_rdata;

  dcache_top u_dut (
    .clk, .rst, .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_strobe,
    .cpu_ready, .cpu_ok, .cpu_rdata,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_data_ok, .mem_rdata
  );

  mem_bus_model u_mem (
    .clk, .rst, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_data_ok, .mem_rdata,
    .wb_count, .wb_addr, .wb_line
  );

  always #(clk_period / 2) clk = ~clk;

  always @(negedge clk)
    if (mem_req)
      mem_busy++;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic word_t mem_pattern(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t model_read(addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    if (model_mem.exists(wa))
      return model_mem[wa];
    return mem_pattern(wa);
  endfunction

  function automatic void model_write(addr_t a, word_t d, strobe_t s);
    word_t w;
    w = model_read(a);
    for (int b = 0; b < 4; b++)
      if (s[b])
        w[8*b +: 8] = d[8*b +: 8];
    model_mem[{a[31:2], 2'b00}] = w;
  endfunction

  function automatic addr_t make_addr(tag_t t, index_t i, offset_t o);
    return {t, i, o, 2'b00};
  endfunction

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "dcache_tb stopped");
  endtask

  task automatic check_word(string what, word_t got, word_t exp);
    if (got !== exp)
    begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(string what, addr_t got, addr_t exp);
    if (got !== exp)
    begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic require(bit cond, string msg);
    if (!cond)
    begin
      $display("%s", msg);
      abort_run();
    end
  endtask

  // Issues one request and checks the word returned with cpu_ok
  task automatic cpu_access(input logic we, input addr_t a, input word_t d, input strobe_t s);
    word_t expected;
    int busy_before;
    do
      @(negedge clk);
    while (!cpu_ready);
    @(posedge clk);
    #2;
    cpu_req = 1'b1;
    cpu_we = we;
    cpu_addr = a;
    cpu_wdata = d;
    cpu_strobe = s;
    @(posedge clk);  // Accepting edge
    busy_before = mem_busy;
    #2;
    cpu_req = 1'b0;
    last_latency = 0;
    do
    begin
      @(negedge clk);
      last_latency++;
      require(!cpu_ready, "cpu_ready was high while a request was in flight");
    end
    while (!cpu_ok);
    last_rdata = cpu_rdata;
    last_mem_cycles = mem_busy - busy_before;
    if (we)
      model_write(a, d, s);
    expected = model_read(a);
    if (we)
      check_word("write response", last_rdata, expected);
    else
      check_word("read data", last_rdata, expected);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial
  begin
    addr_t a;
    int wb_before;
    tag_t tags [6];
    index_t sets [4];
    void'($urandom(69));
    tags = '{22'h00011, 22'h2a5f3, 22'h13c07, 22'h3fffe, 22'h0b0b0, 22'h1d2e4};
    sets = '{4'd1, 4'd6, 4'd11, 4'd14};
    cpu_req = 1'b0;
    cpu_we = 1'b0;
    cpu_addr = '0;
    cpu_wdata = '0;
    cpu_strobe = '0;
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst = 1'b0;

    // Cold miss
    a = make_addr(22'h00005, 4'd3, 4'd7);
    cpu_access(1'b0, a, '0, '0);
    require(last_mem_cycles > 0, "Read after reset did not use the memory bus");

    cpu_access(1'b1, a, $urandom, strobe_t'($urandom));
    cpu_access(1'b0, a, '0, '0);
    require(last_latency == 1, "Read after write did not answer 1 cycle after acceptance");
    require(last_mem_cycles == 0, "mem_req went high during a hit");

    // Set 9 filled way by way
    wb_before = wb_count;
    for (int t = 0; t < 3; t++)
      cpu_access(1'b1, make_addr(tag_t'(32'h100 + t), 4'd9, offset_t'($urandom)), $urandom, '1);
    cpu_access(1'b0, make_addr(22'h103, 4'd9, 4'd2), '0, '0);
    require(wb_count == wb_before, "A fill into an invalid way wrote a line back");
    cpu_access(1'b1, make_addr(22'h104, 4'd9, 4'd5), $urandom, 4'b0110);
    require(wb_count == wb_before + 1, "Fifth tag in set 9 did not cause one write-back");
    check_addr("write-back line address", wb_addr, make_addr(22'h100, 4'd9, 4'd0));
    for (int k = 0; k < `DCACHE_LINE_WORDS; k++)
      check_word("write-back word", wb_line[k],
                 model_read(make_addr(22'h100, 4'd9, offset_t'(k))));

    // After A B C D and a touch of A the new tag E evicts B
    for (int t = 0; t < 4; t++)
      cpu_access(1'b1, make_addr(tag_t'(32'h200 + t), 4'd12, 4'd0), $urandom, '1);
    cpu_access(1'b0, make_addr(22'h200, 4'd12, 4'd3), '0, '0);
    wb_before = wb_count;
    cpu_access(1'b1, make_addr(22'h204, 4'd12, 4'd1), $urandom, '1);
    require(wb_count == wb_before + 1, "Tag E did not cause one write-back");
    check_addr("evicted line address", wb_addr, make_addr(22'h201, 4'd12, 4'd0));

    for (int i = 0; i < random_ops; i++)
    begin
      a = make_addr(tags[$urandom % 6], sets[$urandom % 4], offset_t'($urandom));
      cpu_access(1'($urandom), a, $urandom, strobe_t'($urandom));
    end

    $display("All tests passed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #((real'(fixed_ops + random_ops) * cycles_per_op + real'(reset_cycles)) * clk_period);
    $display("Watchdog timeout: the tests did not finish in time");
    abort_run();
  end

endmodule

//--- all.f
+incdir+source
source/dcache_pkg.sv
source/cache_ram.sv
source/way_select.sv
source/burst_engine.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verification/mem_bus_model.sv
verification/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator and runs it.
# A failing run ends in $fatal, which gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
  --timescale 1ns/1ps \
  --top-module dcache_tb \
  -f all.f \
  -Mdir obj_dir -o dcache_sim

./obj_dir/dcache_sim
